// ==== common/fetch_pkg.sv ====
// Shared constants and types for the instruction fetch stage
// Widths, memory and predictor sizing, payload types, FSM states

package fetch_pkg;

  ////////////////////////////////////////
  // Datapath sizing
  ////////////////////////////////////////

  localparam int XLEN       = 16;  // Address and instruction width
  localparam int IMEM_DEPTH = 64;  // Instruction words
  localparam int IMEM_AW    = 6;   // Word address width into instruction memory

  ////////////////////////////////////////
  // Predictor sizing
  ////////////////////////////////////////

  localparam int BP_ENTRIES = 16;  // Counter and target entries
  localparam int BP_IW      = 4;   // Index width, taken from PC bits 4..1

  ////////////////////////////////////////
  // Payload types
  ////////////////////////////////////////

  // Byte address of a 16-bit instruction
  typedef logic [XLEN-1:0] pc_t;

  // Raw instruction word
  typedef logic [XLEN-1:0] inst_t;

  // 2-bit saturating counter
  // 0,1 predict not taken; 2,3 predict taken, so bit 1 is the prediction
  typedef logic [1:0] pred_t;

  // Predictor table index
  typedef logic [BP_IW-1:0] bp_idx_t;

  ////////////////////////////////////////
  // Control FSM states
  ////////////////////////////////////////

  typedef enum logic {
    ST_LOAD = 1'b0,  // Host is filling instruction memory
    ST_RUN  = 1'b1   // Fetching every unstalled cycle
  } fetch_state_t;

endpackage

// ==== common/resolve_if.sv ====
// Branch resolution bundle returned from decode
// Carries the resolve strobe, outcome, target and predictor bookkeeping

interface resolve_if;

  logic                     resolve;       // Single-cycle strobe, all fields valid with it
  logic                     taken;         // Actual branch outcome
  fetch_pkg::pc_t           target;        // Actual branch target
  logic                     mispredicted;  // Only meaningful while resolve is high
  fetch_pkg::bp_idx_t       idx;           // Predictor index of the resolved branch
  fetch_pkg::pred_t         old_pred;      // Counter value seen when it was fetched

  // Predictor trains its counter and target tables
  modport pred_side (
    input resolve,
    input taken,
    input target,
    input idx,
    input old_pred
  );

  // PC unit only cares about redirects
  modport pc_side (
    input resolve,
    input taken,
    input target,
    input mispredicted
  );

endinterface

// ==== fetch/fetch_ctrl.sv ====
// Fetch stage control FSM
// Sequences instruction loading after reset, then hands over to running
// Gates host load strobes so nothing is written once running

module fetch_ctrl (
  input  logic clk,
  input  logic rst,          // Synchronous, active high
  input  logic load_strobe,  // One word per strobe from the host
  input  logic last,         // Write address is at the final word
  output logic load_en,      // Qualified write strobe
  output logic run           // Fetch is live
);

  fetch_pkg::fetch_state_t state;       // Current state
  fetch_pkg::fetch_state_t state_nxt;   // Next state

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // Strobes only count while loading
  assign load_en = load_strobe && (state == fetch_pkg::ST_LOAD);
  assign run     = (state == fetch_pkg::ST_RUN);

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    state_nxt = state;                           // Hold by default
    case (state)
      fetch_pkg::ST_LOAD: begin
        if (load_en && last)                     // Final word lands this edge
          state_nxt = fetch_pkg::ST_RUN;
      end
      fetch_pkg::ST_RUN: state_nxt = fetch_pkg::ST_RUN;  // Only reset leaves RUN
      default: state_nxt = fetch_pkg::ST_LOAD;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst)
      state <= fetch_pkg::ST_LOAD;
    else
      state <= state_nxt;
  end

  // No reload path exists, RUN is sticky until reset
  a_run_sticky: assert property (
    @(posedge clk) disable iff (rst)
    state == fetch_pkg::ST_RUN |=> state == fetch_pkg::ST_RUN
  ) else $error("fetch_ctrl left ST_RUN without reset");

endmodule

// ==== fetch/load_counter.sv ====
// Load address counter
// Steps the instruction memory write address per load
// Flags the final word so the FSM can switch to running

module load_counter (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load_en,  // Qualified write strobe
  output logic [fetch_pkg::IMEM_AW-1:0] waddr,    // Write address for this strobe
  output logic                          last      // waddr is the final index
);

  // Final word index, sized to the address
  localparam logic [fetch_pkg::IMEM_AW-1:0] LAST_ADDR =
    fetch_pkg::IMEM_AW'(fetch_pkg::IMEM_DEPTH - 1);

  // First strobe after reset writes word 0
  always_ff @(posedge clk) begin
    if (rst)
      waddr <= '0;
    else if (load_en)
      waddr <= waddr + 1'b1;  // Wraps after the final word, FSM stops strobes by then
  end

  // Combinational so the FSM sees it with the final strobe
  assign last = (waddr == LAST_ADDR);

endmodule

// ==== fetch/instr_mem.sv ====
// Instruction memory
// Synchronous write port used only while loading
// Asynchronous word read addressed by the PC, zeroed when not reading

module instr_mem (
  input  logic                          clk,
  input  logic                          load_en,  // Write strobe from load path
  input  logic [fetch_pkg::IMEM_AW-1:0] waddr,    // Word address
  input  fetch_pkg::inst_t              wdata,    // Word from host
  input  fetch_pkg::pc_t                raddr,    // Byte address, PC
  input  logic                          rd_en,    // Running and not stalled
  output fetch_pkg::inst_t              inst      // Fetched word or 0
);

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  fetch_pkg::inst_t mem [fetch_pkg::IMEM_DEPTH];  // Loaded once after reset

  logic [fetch_pkg::IMEM_AW-1:0] rword;  // Word index of the PC

  always_ff @(posedge clk) begin
    if (load_en)
      mem[waddr] <= wdata;
  end

  ////////////////////////////////////////
  // Read
  ////////////////////////////////////////

  // Bit 0 is the byte offset, upper bits alias
  assign rword = raddr[fetch_pkg::IMEM_AW:1];

  // Bubble is an all-zero word
  assign inst = rd_en ? mem[rword] : '0;

endmodule

// ==== fetch/pred_table.sv ====
// Generic predictor table
// Register array with synchronous clear, one write port and a combinational read
// Entry type is a parameter so counters and targets share this code

module pred_table #(
  parameter type entry_t = fetch_pkg::pred_t  // Payload per entry
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               we,     // Write strobe
  input  fetch_pkg::bp_idx_t widx,   // Write index
  input  fetch_pkg::bp_idx_t ridx,   // Read index
  input  entry_t             wdata,  // Write payload
  output entry_t             rdata   // Read payload, same cycle
);

  entry_t tbl [fetch_pkg::BP_ENTRIES];

  // Clear all entries on reset so predictions start not taken
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < fetch_pkg::BP_ENTRIES; i++)
        tbl[i] <= '0;
    end else if (we) begin
      tbl[widx] <= wdata;  // Visible on the next cycle
    end
  end

  assign rdata = tbl[ridx];

endmodule

// ==== fetch/branch_predictor.sv ====
// Dynamic branch predictor
// 2-bit saturating counter table plus branch target buffer
// Trains on resolve strobes, predicts combinationally from the current PC

module branch_predictor (
  input  logic                clk,
  input  logic                rst,
  input  fetch_pkg::pc_t      pc_curr,      // Current fetch address
  resolve_if.pred_side        rs,           // Resolution feedback from decode
  output fetch_pkg::pred_t    prediction,   // Counter at the current index
  output fetch_pkg::pc_t      pred_target   // Cached target at the current index
);

  fetch_pkg::bp_idx_t ridx;     // Lookup index from the PC
  fetch_pkg::pred_t   cnt_upd;  // Trained counter value
  logic               tgt_we;   // Target buffer write

  // Instruction-aligned PC, skip byte offset bit
  assign ridx = pc_curr[fetch_pkg::BP_IW:1];

  ////////////////////////////////////////
  // Counter training
  ////////////////////////////////////////

  // Based on the counter seen at fetch, not the current table value
  always_comb begin
    if (rs.taken)
      cnt_upd = (rs.old_pred == '1) ? rs.old_pred : rs.old_pred + 2'd1;  // Saturate at 3
    else
      cnt_upd = (rs.old_pred == '0) ? rs.old_pred : rs.old_pred - 2'd1;  // Saturate at 0
  end

  // Targets only worth caching for taken branches
  assign tgt_we = rs.resolve && rs.taken;

  ////////////////////////////////////////
  // Tables
  ////////////////////////////////////////

  pred_table #(.entry_t(fetch_pkg::pred_t)) u_bht (
    .clk   (clk),
    .rst   (rst),
    .we    (rs.resolve),  // Trains even under stall
    .widx  (rs.idx),
    .ridx  (ridx),
    .wdata (cnt_upd),
    .rdata (prediction)
  );

  pred_table #(.entry_t(fetch_pkg::pc_t)) u_btb (
    .clk   (clk),
    .rst   (rst),
    .we    (tgt_we),
    .widx  (rs.idx),
    .ridx  (ridx),
    .wdata (rs.target),
    .rdata (pred_target)
  );

  // An X index would corrupt an unknown entry of both tables
  a_idx_known: assert property (
    @(posedge clk) disable iff (rst)
    rs.resolve |-> !$isunknown(rs.idx)
  ) else $error("resolve strobe with unknown predictor index");

endmodule

// ==== fetch/pc_unit.sv ====
// Program counter unit
// PC register and next-PC select between correction, prediction and sequential
// Updates only while running and not stalled

module pc_unit (
  input  logic             clk,
  input  logic             rst,
  input  logic             run,          // Fetch is live
  input  logic             stall,        // Freeze the PC this cycle
  resolve_if.pc_side       rs,           // Misprediction feedback
  input  fetch_pkg::pred_t prediction,   // Counter for the current PC
  input  fetch_pkg::pc_t   pred_target,  // BTB entry for the current PC
  output fetch_pkg::pc_t   pc_curr,      // Address being fetched
  output fetch_pkg::pc_t   pc_next       // Sequential successor
);

  fetch_pkg::pc_t pc_new;   // Address taken at the next update
  logic           redirect; // Resolved misprediction this cycle
  logic           pc_en;    // PC register enable

  assign pc_next  = pc_curr + 16'd2;              // Wraps at 16 bits
  assign redirect = rs.resolve && rs.mispredicted;
  assign pc_en    = run && !stall;

  ////////////////////////////////////////
  // Next PC priority
  ////////////////////////////////////////

  always_comb begin
    if (redirect)
      pc_new = rs.taken ? rs.target : pc_next;  // Correction beats prediction
    else if (prediction[1])
      pc_new = pred_target;                     // Predicted taken
    else
      pc_new = pc_next;
  end

  ////////////////////////////////////////
  // PC register
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst)
      pc_curr <= '0;  // First fetch is word 0
    else if (pc_en)
      pc_curr <= pc_new;
  end

  // Targets from decode and the BTB must be halfword aligned
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (rst)
    pc_curr[0] == 1'b0
  ) else $error("pc_curr misaligned: %h", pc_curr);

endmodule

// ==== source/fetch_top.sv ====
// Instruction fetch stage top level
// Plain ports outward, resolve fields bundled into resolve_if inside
// Wires control, load counter, instruction memory, predictor and PC unit

module fetch_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               load_strobe,   // Host write, one word per strobe
  input  fetch_pkg::inst_t   load_data,     // Host write data
  input  logic               stall,         // Level, freezes fetch
  input  logic               resolve,       // Branch resolved in decode
  input  logic               taken,         // Actual outcome
  input  fetch_pkg::pc_t     target,        // Actual target
  input  logic               mispredicted,  // Prediction was wrong
  input  fetch_pkg::bp_idx_t resolve_idx,   // Predictor index of the branch
  input  fetch_pkg::pred_t   resolve_pred,  // Counter seen at its fetch
  output logic               fetch_valid,   // inst is a real fetch this cycle
  output fetch_pkg::pc_t     pc_curr,
  output fetch_pkg::pc_t     pc_next,
  output fetch_pkg::inst_t   inst,
  output fetch_pkg::pred_t   prediction
);

  logic                          load_en;      // Qualified load strobe
  logic                          run;          // FSM in ST_RUN
  logic                          last;         // Final load word
  logic [fetch_pkg::IMEM_AW-1:0] waddr;        // Load write address
  fetch_pkg::pc_t                pred_target;  // BTB output

  resolve_if u_rs ();

  assign u_rs.resolve      = resolve;
  assign u_rs.taken        = taken;
  assign u_rs.target       = target;
  assign u_rs.mispredicted = mispredicted;
  assign u_rs.idx          = resolve_idx;
  assign u_rs.old_pred     = resolve_pred;

  assign fetch_valid = run && !stall;  // Also the memory read enable

  fetch_ctrl u_ctrl (
    .clk(clk), .rst(rst), .load_strobe(load_strobe), .last(last),
    .load_en(load_en), .run(run)
  );

  load_counter u_lcnt (.clk(clk), .rst(rst), .load_en(load_en), .waddr(waddr), .last(last));

  instr_mem u_imem (
    .clk(clk), .load_en(load_en), .waddr(waddr), .wdata(load_data),
    .raddr(pc_curr), .rd_en(fetch_valid), .inst(inst)
  );

  branch_predictor u_bp (
    .clk(clk), .rst(rst), .pc_curr(pc_curr), .rs(u_rs),
    .prediction(prediction), .pred_target(pred_target)
  );

  pc_unit u_pc (
    .clk(clk), .rst(rst), .run(run), .stall(stall), .rs(u_rs),
    .prediction(prediction), .pred_target(pred_target),
    .pc_curr(pc_curr), .pc_next(pc_next)
  );

endmodule

// ==== sim/fetch_tb.sv ====
// Trace-driven testbench for the instruction fetch stage
// Reads load words and per-cycle records, drives fetch_top, checks its outputs
// Watchdog sized from the trace length, closing error count and verdict

module fetch_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int    CLK_PERIOD = 8;
  localparam int    RST_CYCLES = 10;
  localparam string TRACE_FILE = "sim/fetch_trace.txt";

  // One run-phase cycle: stimulus then expected outputs
  typedef struct {
    logic                    stall;
    logic                    resolve;
    logic                    taken;
    fetch_pkg::pc_t          target;
    logic                    mispredicted;
    fetch_pkg::bp_idx_t      idx;
    fetch_pkg::pred_t        old_pred;
    logic                    exp_valid;
    fetch_pkg::pc_t          exp_pc;
    fetch_pkg::inst_t        exp_inst;
    fetch_pkg::pred_t        exp_pred;
  } record_t;

  ////////////////////////////////////////
  // DUT and clock
  ////////////////////////////////////////

  logic               clk = 1'b0;
  logic               rst;
  logic               load_strobe;
  fetch_pkg::inst_t   load_data;
  logic               stall;
  logic               resolve;
  logic               taken;
  fetch_pkg::pc_t     target;
  logic               mispredicted;
  fetch_pkg::bp_idx_t resolve_idx;
  fetch_pkg::pred_t   resolve_pred;
  logic               fetch_valid;
  fetch_pkg::pc_t     pc_curr;
  fetch_pkg::pc_t     pc_next;
  fetch_pkg::inst_t   inst;
  fetch_pkg::pred_t   prediction;

  logic [15:0] load_words [$];   // Memory image, word 0 first
  record_t     records [$];      // Run-phase cycles in order
  int          errors = 0;
  int          checks = 0;
  bit          trace_ready = 1'b0;  // Starts the watchdog
  int          timeout_cycles;

  always #(CLK_PERIOD / 2) clk = ~clk;

  fetch_top u_dut (
    .clk(clk), .rst(rst), .load_strobe(load_strobe), .load_data(load_data),
    .stall(stall), .resolve(resolve), .taken(taken), .target(target),
    .mispredicted(mispredicted), .resolve_idx(resolve_idx), .resolve_pred(resolve_pred),
    .fetch_valid(fetch_valid), .pc_curr(pc_curr), .pc_next(pc_next),
    .inst(inst), .prediction(prediction)
  );

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Fills load_words and records, ok low on any parse problem
  task automatic read_trace(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [15:0] w [8];
    logic [15:0] v [11];
    record_t     rec;
    ok = 1'b0;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open trace file %s", TRACE_FILE);
      return;
    end
    while ($fgets(line, fd) > 0) begin
      if (line.len() == 0 || line[0] == "#" || line[0] == "\n")
        continue;                                    // Comment or blank
      if (line[0] == "L") begin
        n = $sscanf(line, "L %h %h %h %h %h %h %h %h",
                    w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7]);
        if (n != 8) begin
          $display("Trace load line has %0d words instead of 8", n);
          $fclose(fd);
          return;
        end
        foreach (w[i])
          load_words.push_back(w[i]);
      end else if (line[0] == "C") begin
        n = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
        if (n != 11) begin
          $display("Trace cycle line has %0d fields instead of 11", n);
          $fclose(fd);
          return;
        end
        rec.stall        = v[0][0];
        rec.resolve      = v[1][0];
        rec.taken        = v[2][0];
        rec.target       = v[3];
        rec.mispredicted = v[4][0];
        rec.idx          = v[5][3:0];
        rec.old_pred     = v[6][1:0];
        rec.exp_valid    = v[7][0];
        rec.exp_pc       = v[8];
        rec.exp_inst     = v[9];
        rec.exp_pred     = v[10][1:0];
        records.push_back(rec);
      end else begin
        $display("Trace line with unknown tag found");
        $fclose(fd);
        return;
      end
    end
    $fclose(fd);
    if (load_words.size() != fetch_pkg::IMEM_DEPTH) begin
      $display("Trace holds %0d load words, memory needs %0d",
               load_words.size(), fetch_pkg::IMEM_DEPTH);
      return;
    end
    ok = 1'b1;
  endtask

  task automatic apply_reset();
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    #(CLK_PERIOD - 1);                               // Just before the next edge
    check("reset fetch_valid", 16'(0), 16'(fetch_valid));
    check("reset pc_curr", 16'h0000, pc_curr);
    check("reset inst", 16'h0000, inst);
  endtask

  // One strobe per word, nothing fetched while loading
  task automatic load_memory();
    for (int i = 0; i < load_words.size(); i++) begin
      @(posedge clk);
      load_strobe <= 1'b1;
      load_data   <= load_words[i];
      #(CLK_PERIOD - 1);
      check($sformatf("load %0d fetch_valid", i), 16'(0), 16'(fetch_valid));
      check($sformatf("load %0d inst", i), 16'h0000, inst);
      check($sformatf("load %0d pc_curr", i), 16'h0000, pc_curr);
    end
  endtask

  task automatic run_record(input int k);
    record_t r;
    r = records[k];
    @(posedge clk);
    load_strobe  <= 1'b0;
    stall        <= r.stall;
    resolve      <= r.resolve;
    taken        <= r.taken;
    target       <= r.target;
    mispredicted <= r.mispredicted;
    resolve_idx  <= r.idx;
    resolve_pred <= r.old_pred;
    #(CLK_PERIOD - 1);
    check($sformatf("cycle %0d fetch_valid", k), 16'(r.exp_valid), 16'(fetch_valid));
    check($sformatf("cycle %0d pc_curr", k), r.exp_pc, pc_curr);
    check($sformatf("cycle %0d pc_next", k), r.exp_pc + 16'd2, pc_next);  // Wraps at 16 bits
    check($sformatf("cycle %0d inst", k), r.exp_inst, inst);
    check($sformatf("cycle %0d prediction", k), 16'(r.exp_pred), 16'(prediction));
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    bit ok;
    rst          = 1'b1;
    load_strobe  = 1'b0;
    load_data    = '0;
    stall        = 1'b0;
    resolve      = 1'b0;
    taken        = 1'b0;
    target       = '0;
    mispredicted = 1'b0;
    resolve_idx  = '0;
    resolve_pred = '0;
    read_trace(ok);
    if (!ok) begin
      errors++;
    end else begin
      timeout_cycles = 10 * (load_words.size() + records.size());
      trace_ready    = 1'b1;
      apply_reset();
      load_memory();
      foreach (records[k])
        run_record(k);
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial begin
    wait (trace_ready);
    #(timeout_cycles * CLK_PERIOD);
    $display("Watchdog expired after %0d clock periods, run did not complete",
             timeout_cycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== sim/fetch_trace.txt ====
# L rows: tag, then 8 hex load words in ascending address order from word 0
# C rows: tag, stall resolve taken target mispredicted idx old_pred, then expected fetch_valid pc_curr inst prediction
L 1000 1101 1202 1303 1404 1505 1606 1707
L 1808 1909 1a0a 1b0b 1c0c 1d0d 1e0e 1f0f
L 2010 2111 2212 2313 2414 2515 2616 2717
L 2818 2919 2a1a 2b1b 2c1c 2d1d 2e1e 2f1f
L 3020 3121 3222 3323 3424 3525 3626 3727
L 3828 3929 3a2a 3b2b 3c2c 3d2d 3e2e 3f2f
L 4030 4131 4232 4333 4434 4535 4636 4737
L 4838 4939 4a3a 4b3b 4c3c 4d3d 4e3e 4f3f
# Sequential fetch, then one stall cycle
C 0 0 0 0000 0 0 0  1 0000 1000 0
C 0 0 0 0000 0 0 0  1 0002 1101 0
C 0 0 0 0000 0 0 0  1 0004 1202 0
C 1 0 0 0000 0 0 0  0 0006 0000 0
# Taken resolve trains idx 5, PC 000a then follows the stored target
C 0 1 1 0020 0 5 1  1 0006 1303 0
C 0 0 0 0000 0 0 0  1 0008 1404 0
C 0 0 0 0000 0 0 0  1 000a 1505 2
# Mispredicted taken redirect, then mispredicted not-taken over a taken prediction
C 0 1 1 0040 1 0 1  1 0020 2010 0
C 0 1 0 0000 1 0 2  1 0040 3020 2
# Saturation at 3 on idx 3, at 0 on idx 2, one resolve under stall
C 0 1 1 0060 0 3 3  1 0042 3121 0
C 0 1 1 0060 0 3 3  1 0044 3222 0
C 0 0 0 0000 0 0 0  1 0046 3323 3
C 0 1 0 0000 0 2 0  1 0060 4030 1
C 1 1 0 0000 0 2 0  0 0062 0000 0
C 0 0 0 0000 0 0 0  1 0062 4131 0
C 0 0 0 0000 0 0 0  1 0064 4232 0

// ==== list.f ====
common/fetch_pkg.sv
common/resolve_if.sv
fetch/fetch_ctrl.sv
fetch/load_counter.sv
fetch/instr_mem.sv
fetch/pred_table.sv
fetch/branch_predictor.sv
fetch/pc_unit.sv
source/fetch_top.sv
sim/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the fetch stage testbench with Verilator, run it, and grade the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module fetch_tb \
  --Mdir obj_dir -o fetch_sim \
  && ./obj_dir/fetch_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null

grep -q "^Finished with no errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
